//--- include/core_consts.svh
////////////////////////////////////////////////////////////////////////////
// Sizing constants for the scalar out-of-order core
// Included by the packages and by every RTL block that sizes an array
////////////////////////////////////////////////////////////////////////////
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path width
`define XLEN 32

// Register counts, eight architectural mapped onto sixteen physical
`define ARCH_REGS 8
`define PHYS_REGS 16

// Queue depths
`define ROB_DEPTH 8
`define RS_DEPTH 4

// Multiplier pipe latency in cycles
`define MUL_STAGES 4

`endif

//--- hw/isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// RISC-V subset encoding types
// ADD, SUB, MUL from the OP major opcode and ADDI from OP-IMM
////////////////////////////////////////////////////////////////////////////
`include "core_consts.svh"

package isa_pkg;

    // One data word
    typedef logic [`XLEN-1:0] data_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // Only registers x0..x7 exist
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // Major opcodes in bits 6:0
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_t;

    // Bits 31:25 for the OP register-register forms
    typedef enum logic [6:0] {
        F7_BASE   = 7'h00,
        F7_MULDIV = 7'h01,
        F7_SUB    = 7'h20
    } funct7_t;

endpackage

//--- hw/core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Microarchitecture types shared by rename, station, execute and ROB
////////////////////////////////////////////////////////////////////////////
`include "core_consts.svh"

package core_pkg;
    import isa_pkg::*;

    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // Operation selected at decode
    typedef enum logic [1:0] {FU_ADD, FU_SUB, FU_MUL} fu_op_t;

    // Station entry, also the issue packet
    typedef struct packed {
        fu_op_t    op;
        phys_tag_t src1_tag;
        logic      src1_ready;
        phys_tag_t src2_tag;
        logic      src2_ready;
        data_t     imm;
        logic      use_imm;
        phys_tag_t dest_tag;
        rob_idx_t  rob_idx;
    } dispatch_t;

    // Single result bus
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        data_t     value;
        rob_idx_t  rob_idx;
    } cdb_t;

    typedef struct packed {
        arch_reg_t rd;
        logic      has_dest;
        logic      illegal;
        data_t     value;
    } commit_t;

    // ROB slot contents written at dispatch
    typedef struct packed {
        arch_reg_t rd;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
        logic      has_dest;
        logic      illegal;
    } rob_alloc_t;

    // Four-phase input handshake
    typedef enum logic {HS_IDLE, HS_ACK_HIGH} hs_state_t;

endpackage

//--- hw/rename_dispatch.sv
////////////////////////////////////////////////////////////////////////////
// Input handshake, decode and register rename
// Accepts one instruction per four-phase req/ack cycle, renames it through
// the map, free and ready tables and hands it to the ROB and the station
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "core_consts.svh"

module rename_dispatch import isa_pkg::*, core_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       inst_req,
    input  instr_t     inst,
    output logic       inst_ack,
    input  rob_idx_t   rob_tail,
    input  logic       rob_full,
    input  logic       rs_full,
    input  cdb_t       cdb,
    input  logic       free_valid,
    input  phys_tag_t  free_tag,
    output logic       rob_alloc_valid,
    output rob_alloc_t rob_alloc,
    output logic       rs_alloc_valid,
    output dispatch_t  rs_alloc
);

    hs_state_t state_q;
    phys_tag_t map_q [`ARCH_REGS];
    logic [`PHYS_REGS-1:0] ready_q;
    logic [`PHYS_REGS-1:0] free_q;

    opcode_t   opcode;
    funct7_t   funct7;
    arch_reg_t rd;
    arch_reg_t rs1;
    arch_reg_t rs2;
    logic      is_op;
    logic      is_addi;
    logic      illegal;
    logic      has_dest;
    logic      free_any;
    phys_tag_t new_tag;
    logic      dispatch;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////
    assign opcode  = opcode_t'(inst[6:0]);
    assign funct7  = funct7_t'(inst[31:25]);
    assign rd      = arch_reg_t'(inst[9:7]);
    assign rs1     = arch_reg_t'(inst[17:15]);
    assign rs2     = arch_reg_t'(inst[22:20]);
    assign is_op   = (opcode == OPC_OP) && (inst[14:12] == 3'b000) &&
                     (funct7 inside {F7_BASE, F7_SUB, F7_MULDIV});
    assign is_addi = (opcode == OPC_OP_IMM) && (inst[14:12] == 3'b000);
    // Register fields above x7 are rejected, rs2 only matters for OP
    assign illegal = !(is_op || is_addi) || (inst[11:10] != 2'b00) ||
                     (inst[19:18] != 2'b00) || (is_op && inst[24:23] != 2'b00);
    // x0 is never renamed
    assign has_dest = !illegal && (rd != '0);

    // Lowest free tag
    always_comb begin
        free_any = 1'b0;
        new_tag  = '0;
        for (int i = `PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                free_any = 1'b1;
                new_tag  = phys_tag_t'(i);
            end
        end
    end

    // Accept only from idle with room everywhere
    assign dispatch = (state_q == HS_IDLE) && inst_req && !rob_full && !rs_full && free_any;
    assign inst_ack = (state_q == HS_ACK_HIGH);

    always_comb begin
        rob_alloc          = '{rd: rd, new_tag: new_tag, old_tag: map_q[rd],
                               has_dest: has_dest, illegal: illegal};
        rs_alloc.op        = (is_op && funct7 == F7_SUB)    ? FU_SUB :
                             (is_op && funct7 == F7_MULDIV) ? FU_MUL : FU_ADD;
        rs_alloc.src1_tag  = map_q[rs1];
        rs_alloc.src2_tag  = map_q[rs2];
        // Same-cycle wakeup so a broadcast is never missed
        rs_alloc.src1_ready = ready_q[map_q[rs1]] || (cdb.valid && cdb.tag == map_q[rs1]);
        rs_alloc.src2_ready = is_addi || ready_q[map_q[rs2]] ||
                              (cdb.valid && cdb.tag == map_q[rs2]);
        rs_alloc.imm       = {{(`XLEN - 12){inst[31]}}, inst[31:20]};
        rs_alloc.use_imm   = is_addi;
        // Tag 0 stays bound to x0 and absorbs writes to it
        rs_alloc.dest_tag  = has_dest ? new_tag : '0;
        rs_alloc.rob_idx   = rob_tail;
    end

    assign rob_alloc_valid = dispatch;
    assign rs_alloc_valid  = dispatch && !illegal;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= HS_IDLE;
            for (int i = 0; i < `ARCH_REGS; i++) map_q[i] <= phys_tag_t'(i);
            ready_q <= '1;
            for (int i = 0; i < `PHYS_REGS; i++) free_q[i] <= (i >= `ARCH_REGS);
        end else begin
            if (dispatch) state_q <= HS_ACK_HIGH;
            else if (state_q == HS_ACK_HIGH && !inst_req) state_q <= HS_IDLE;
            if (cdb.valid) ready_q[cdb.tag] <= 1'b1;
            if (free_valid) free_q[free_tag] <= 1'b1;
            if (dispatch && has_dest) begin
                map_q[rd]        <= new_tag;
                ready_q[new_tag] <= 1'b0;
                free_q[new_tag]  <= 1'b0;
            end
        end
    end

    // Tags outnumber ROB slots, so the free list only runs dry with a full ROB
    a_free_vs_rob: assert property (@(posedge clock) disable iff (!arst_n)
        !rob_full |-> free_any);

endmodule

//--- hw/reservation_station.sv
////////////////////////////////////////////////////////////////////////////
// Unified reservation station
// Collapsing queue, slot 0 holds the oldest entry; operands wake from the
// CDB and the oldest ready entry is issued each cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "core_consts.svh"

module reservation_station import core_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      rs_alloc_valid,
    input  dispatch_t rs_alloc,
    input  cdb_t      cdb,
    input  logic      alu_blocked,
    output logic      rs_full,
    output logic      issue_valid,
    output dispatch_t issue
);

    logic [`RS_DEPTH-1:0] valid_q;
    dispatch_t            ent_q [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] valid_d;
    dispatch_t            ent_d [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] ready;
    logic [$clog2(`RS_DEPTH)-1:0] sel;
    logic                 placed;

    assign rs_full = &valid_q;

    // Ready entries, ALU ops held back while the CDB slot is taken
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready[i] = valid_q[i] && ent_q[i].src1_ready && ent_q[i].src2_ready &&
                       (ent_q[i].op == FU_MUL || !alu_blocked);
        end
    end

    // Oldest ready wins
    always_comb begin
        sel = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) sel = i[$clog2(`RS_DEPTH)-1:0];
        end
    end

    assign issue_valid = |ready;
    assign issue       = ent_q[sel];

    // Next state: wakeup, remove the issued slot, append the new entry
    always_comb begin
        placed  = 1'b0;
        valid_d = valid_q;
        ent_d   = ent_q;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (cdb.valid && cdb.tag == ent_d[i].src1_tag) ent_d[i].src1_ready = 1'b1;
            if (cdb.valid && cdb.tag == ent_d[i].src2_tag) ent_d[i].src2_ready = 1'b1;
        end
        if (issue_valid) begin
            for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                if (i >= int'(sel)) begin
                    valid_d[i] = valid_d[i+1];
                    ent_d[i]   = ent_d[i+1];
                end
            end
            valid_d[`RS_DEPTH-1] = 1'b0;
        end
        // Entries stay packed at the bottom, so the first hole is the tail
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (rs_alloc_valid && !placed && !valid_d[i]) begin
                valid_d[i] = 1'b1;
                ent_d[i]   = rs_alloc;
                placed     = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) valid_q <= '0;
        else         valid_q <= valid_d;
    end

    always_ff @(posedge clock) begin
        ent_q <= ent_d;
    end

    // Every accepted entry lands in a free slot after the collapse
    a_no_alloc_full: assert property (@(posedge clock) disable iff (!arst_n)
        rs_alloc_valid |-> placed);

endmodule

//--- hw/execute_cdb.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage and CDB driver
// Reads operands from the physical register file, runs a one-cycle ALU and
// a pipelined multiplier, and broadcasts each result on the single CDB
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "core_consts.svh"

module execute_cdb import isa_pkg::*, core_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      issue_valid,
    input  dispatch_t issue,
    output logic      alu_blocked,
    output cdb_t      cdb
);

    data_t prf_q [`PHYS_REGS];
    data_t op_a;
    data_t op_b;
    cdb_t  alu_d;
    cdb_t  alu_q;
    cdb_t  mul_d;
    cdb_t  mul_q [`MUL_STAGES];

    // Operand read, producers already wrote the file before wakeup
    assign op_a = prf_q[issue.src1_tag];
    assign op_b = issue.use_imm ? issue.imm : prf_q[issue.src2_tag];

    always_comb begin
        alu_d.valid   = issue_valid && (issue.op != FU_MUL);
        alu_d.tag     = issue.dest_tag;
        alu_d.value   = (issue.op == FU_SUB) ? (op_a - op_b) : (op_a + op_b);
        alu_d.rob_idx = issue.rob_idx;
        // Low word of the product only
        mul_d.valid   = issue_valid && (issue.op == FU_MUL);
        mul_d.tag     = issue.dest_tag;
        mul_d.value   = op_a * op_b;
        mul_d.rob_idx = issue.rob_idx;
    end

    // A mul one stage from the end owns the next CDB slot
    assign alu_blocked = mul_q[`MUL_STAGES-2].valid;

    // Result bus
    assign cdb = alu_q.valid ? alu_q : mul_q[`MUL_STAGES-1];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            alu_q <= '0;
            mul_q <= '{default: '0};
        end else begin
            alu_q    <= alu_d;
            mul_q[0] <= mul_d;
            for (int i = 1; i < `MUL_STAGES; i++) mul_q[i] <= mul_q[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Physical register file
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prf_q <= '{default: '0};
        end else if (cdb.valid && cdb.tag != '0) begin
            // Tag 0 is x0 and keeps zero
            prf_q[cdb.tag] <= cdb.value;
        end
    end

    // Station hold-off keeps the two units off the bus together
    a_cdb_single: assert property (@(posedge clock) disable iff (!arst_n)
        !(alu_q.valid && mul_q[`MUL_STAGES-1].valid));

endmodule

//--- hw/reorder_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Reorder buffer
// Circular queue of in-flight instructions; marks completion from the CDB,
// retires the head in order and returns its old tag to the free list
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "core_consts.svh"

module reorder_buffer import isa_pkg::*, core_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       rob_alloc_valid,
    input  rob_alloc_t rob_alloc,
    input  cdb_t       cdb,
    output rob_idx_t   rob_tail,
    output logic       rob_full,
    output logic       free_valid,
    output phys_tag_t  free_tag,
    output logic       commit_valid,
    output commit_t    commit
);

    localparam int CW = $clog2(`ROB_DEPTH) + 1;

    rob_alloc_t rob_q [`ROB_DEPTH];
    data_t      value_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_q;
    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    logic [CW-1:0] count_q;
    logic       retire;

    assign rob_tail = tail_q;
    assign rob_full = (count_q == CW'(`ROB_DEPTH));
    assign retire   = (count_q != '0) && done_q[head_q];

    // Freed at the retire edge, together with the count drop
    assign free_valid = retire && rob_q[head_q].has_dest;
    assign free_tag   = rob_q[head_q].old_tag;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            done_q       <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (cdb.valid) done_q[cdb.rob_idx] <= 1'b1;
            // Illegal entries are complete from the start
            if (rob_alloc_valid) begin
                done_q[tail_q] <= rob_alloc.illegal;
                tail_q         <= tail_q + 1'b1;
            end
            if (retire) head_q <= head_q + 1'b1;
            count_q <= count_q + CW'(rob_alloc_valid) - CW'(retire);
        end
    end

    // Slot payload and commit packet
    always_ff @(posedge clock) begin
        if (rob_alloc_valid) begin
            rob_q[tail_q]   <= rob_alloc;
            value_q[tail_q] <= '0;
        end
        if (cdb.valid) value_q[cdb.rob_idx] <= cdb.value;
        commit <= '{rd: rob_q[head_q].rd, has_dest: rob_q[head_q].has_dest,
                    illegal: rob_q[head_q].illegal, value: value_q[head_q]};
    end

endmodule

//--- hw/ooo_core.sv
////////////////////////////////////////////////////////////////////////////
// Scalar out-of-order core
// Instructions enter over a req/ack handshake, commits leave as a pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module ooo_core import isa_pkg::*, core_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    input  logic    inst_req,
    input  instr_t  inst,
    output logic    inst_ack,
    output logic    commit_valid,
    output commit_t commit
);

    // Dispatch
    logic       rob_alloc_valid, rs_alloc_valid, rob_full, rs_full;
    rob_alloc_t rob_alloc;
    dispatch_t  rs_alloc;
    rob_idx_t   rob_tail;
    // Issue, completion and retire
    logic       issue_valid, alu_blocked, free_valid;
    dispatch_t  issue;
    cdb_t       cdb;
    phys_tag_t  free_tag;

    rename_dispatch i_rename_dispatch (.*);

    reservation_station i_reservation_station (.*);

    execute_cdb i_execute_cdb (.*);

    reorder_buffer i_reorder_buffer (.*);

endmodule

//--- verif/ooo_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the scalar out-of-order core
// Feeds instructions over the req/ack handshake, predicts every commit with
// an architectural model and checks the commit stream in program order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module ooo_core_tb import isa_pkg::*, core_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    // Setup and body of tests 2 to 6
    localparam int TOTAL_INSTRS   = 6 + 5 + 14 + 5 + 150;
    localparam int TIMEOUT_CYCLES = 200 * TOTAL_INSTRS + 1000;

    logic    clock;
    logic    arst_n;
    logic    inst_req;
    instr_t  inst;
    logic    inst_ack;
    logic    commit_valid;
    commit_t commit;

    // Architectural state of the model and commits still to come
    data_t   arch_regs [8];
    commit_t expected_q [$];
    string   test_name;
    int      error_count;
    int      errors_at_start;
    int      check_count;
    int      tests_run;
    int      tests_passed;
    integer  seed;

    ooo_core i_dut (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////
    // Encoders and reference model
    ////////////////////////////////////////////////////////////////////////
    function automatic instr_t enc_op(input logic [6:0] f7, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic instr_t enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // Expected commit of one instruction, queued in program order
    function automatic commit_t predict(input instr_t word);
        commit_t exp;
        logic    is_op;
        logic    is_addi;
        data_t   a;
        data_t   b;
        is_op   = (word[6:0] == 7'b0110011) && (word[14:12] == 3'b000) &&
                  (word[31:25] inside {7'h00, 7'h01, 7'h20});
        is_addi = (word[6:0] == 7'b0010011) && (word[14:12] == 3'b000);
        a = arch_regs[word[17:15]];
        b = is_addi ? {{20{word[31]}}, word[31:20]} : arch_regs[word[22:20]];
        // Any register field that reaches past x7 is illegal
        exp.illegal  = !(is_op || is_addi) || (word[11:10] != 2'b00) ||
                       (word[19:18] != 2'b00) || (is_op && word[24:23] != 2'b00);
        exp.has_dest = !exp.illegal && (word[11:7] != 5'd0);
        exp.rd       = word[9:7];
        if (is_op && word[31:25] == 7'h20) exp.value = a - b;
        else if (is_op && word[31:25] == 7'h01) exp.value = a * b;
        else exp.value = a + b;
        if (exp.has_dest) arch_regs[word[9:7]] = exp.value;
        expected_q.push_back(exp);
        return exp;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////
    // Full four-phase cycle for one instruction
    task automatic send_instr(input instr_t word);
        void'(predict(word));
        @(posedge clock);
        inst_req <= 1'b1;
        inst     <= word;
        do @(posedge clock); while (!inst_ack);
        inst_req <= 1'b0;
        do @(posedge clock); while (inst_ack);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    // Drain the expected queue, then report the test
    task automatic end_test();
        while (expected_q.size() != 0) @(negedge clock);
        repeat (2) @(negedge clock);
        tests_run++;
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("PASS  %s", test_name);
        end else begin
            $display("FAIL  %s (%0d errors)", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic check_quiet_outputs();
        check_count++;
        assert (!inst_ack && !commit_valid) else begin
            $display("%s: inst_ack or commit_valid high around reset", test_name);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Commit checker
    ////////////////////////////////////////////////////////////////////////
    always @(posedge clock) begin
        commit_t exp;
        if (arst_n && commit_valid) begin
            check_count++;
            assert (expected_q.size() != 0) else begin
                $display("%s: commit seen with no instruction outstanding", test_name);
                error_count++;
            end
            if (expected_q.size() != 0) begin
                exp = expected_q.pop_front();
                assert (commit.illegal == exp.illegal && commit.has_dest == exp.has_dest)
                else begin
                    $display("** Error %s: expected illegal=%b has_dest=%b, actual %b %b",
                             test_name, exp.illegal, exp.has_dest,
                             commit.illegal, commit.has_dest);
                    error_count++;
                end
                // Value only matters when a register is written
                if (exp.has_dest) begin
                    assert (commit.rd == exp.rd && commit.value == exp.value) else begin
                        $display("** Error %s: expected x%0d=%h, actual x%0d=%h", test_name,
                                 exp.rd, exp.value, commit.rd, commit.value);
                        error_count++;
                    end
                end
            end
        end
    end

    // Watchdog sized from the instruction count
    initial begin
        #(CLK_PERIOD * TIMEOUT_CYCLES);
        $display("Timeout: the core stopped accepting or committing instructions");
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        clock    = 1'b0;
        arst_n   = 1'b0;
        inst_req = 1'b0;
        inst     = '0;
        seed     = 32'hc4b;
        foreach (arch_regs[i]) arch_regs[i] = '0;

        start_test("reset");
        repeat (3) begin
            @(posedge clock);
            check_quiet_outputs();
        end
        arst_n <= 1'b1;
        @(posedge clock);
        check_quiet_outputs();
        end_test();

        start_test("dependent_chain");
        send_instr(enc_addi(5'd1, 5'd0, 12'd5));
        send_instr(enc_addi(5'd2, 5'd1, -12'sd3));
        send_instr(enc_op(7'h00, 5'd3, 5'd1, 5'd2));
        send_instr(enc_op(7'h20, 5'd4, 5'd3, 5'd1));
        send_instr(enc_op(7'h00, 5'd5, 5'd4, 5'd4));
        send_instr(enc_op(7'h20, 5'd6, 5'd0, 5'd5));
        end_test();

        // ADDs finish ahead of the MUL but retire behind it
        start_test("mul_then_independent_adds");
        send_instr(enc_op(7'h01, 5'd7, 5'd1, 5'd2));
        send_instr(enc_op(7'h00, 5'd3, 5'd1, 5'd1));
        send_instr(enc_op(7'h00, 5'd4, 5'd2, 5'd2));
        send_instr(enc_addi(5'd5, 5'd5, 12'd1));
        send_instr(enc_op(7'h00, 5'd6, 5'd7, 5'd3));
        end_test();

        start_test("mul_burst");
        send_instr(enc_addi(5'd1, 5'd0, -12'sd7));
        send_instr(enc_addi(5'd6, 5'd0, -12'sd3));
        for (int i = 0; i < 12; i++) begin
            send_instr(enc_op(7'h01, 5'(1 + (i + 1) % 5), 5'(1 + i % 5), 5'd6));
        end
        end_test();

        // x9 aliases x1 in the low bits and must leave x1 alone
        start_test("illegal_and_x0");
        send_instr({12'h004, 5'd1, 3'b010, 5'd2, 7'b0000011});
        send_instr(enc_op(7'h00, 5'd9, 5'd1, 5'd2));
        send_instr(enc_addi(5'd0, 5'd1, 12'd100));
        send_instr(enc_op(7'h00, 5'd2, 5'd1, 5'd0));
        send_instr(enc_op(7'h00, 5'd3, 5'd1, 5'd1));
        end_test();

        start_test("random_program");
        for (int i = 0; i < 150; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: send_instr(enc_op(7'h00, {2'b00, r[4:2]}, {2'b00, r[7:5]},
                                        {2'b00, r[10:8]}));
                2'd1: send_instr(enc_op(7'h20, {2'b00, r[4:2]}, {2'b00, r[7:5]},
                                        {2'b00, r[10:8]}));
                2'd2: send_instr(enc_op(7'h01, {2'b00, r[4:2]}, {2'b00, r[7:5]},
                                        {2'b00, r[10:8]}));
                default: send_instr(enc_addi({2'b00, r[4:2]}, {2'b00, r[7:5]}, r[31:20]));
            endcase
        end
        end_test();

        // Room for any stray commit to show up
        repeat (10) @(posedge clock);
        $display("Tests: %0d run, %0d passed, %0d failed; checks %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, check_count, error_count);
        if (error_count == 0 && tests_passed == tests_run) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hw/isa_pkg.sv
hw/core_pkg.sv
hw/rename_dispatch.sv
hw/reservation_station.sv
hw/execute_cdb.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
verif/ooo_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the core and its testbench with Verilator, run it and check the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module ooo_core_tb -o ooo_core_sim \
    && ./obj_dir/ooo_core_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
